//--- build.f
+incdir+.
dcache_pkg.sv
dcache_plru.sv
dcache_array.sv
dcache_miss_buffer.sv
dcache_load_result.sv
dcache_top.sv
tb_dcache.sv

//--- dcache_array.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_array (
    input  logic                     clock,
    input  logic                     reset,
    input  dcache_pkg::addr_t        load_addr,
    input  logic                     store_valid,
    input  dcache_pkg::addr_t        store_addr,
    input  dcache_pkg::mem_size_t    store_size,
    input  logic [31:0]              store_data,
    input  logic                     fill_valid,
    input  dcache_pkg::set_idx_t     fill_set,
    input  dcache_pkg::way_idx_t     fill_way,
    input  dcache_pkg::cache_tag_t   fill_tag,
    input  dcache_pkg::cache_block_t fill_block,
    output logic                     load_hit,
    output dcache_pkg::way_idx_t     load_hit_way,
    output dcache_pkg::cache_block_t load_hit_block,
    output logic                     store_hit,
    output dcache_pkg::way_idx_t     store_hit_way
);
    import dcache_pkg::*;

    localparam int TAG_LSB = `DCACHE_OFFSET_BITS + `DCACHE_SET_BITS;

    logic [`DCACHE_SETS-1:0][`DCACHE_WAYS-1:0] valid_bits;
    cache_tag_t   tags   [`DCACHE_SETS][`DCACHE_WAYS];
    cache_block_t blocks [`DCACHE_SETS][`DCACHE_WAYS];

    set_idx_t     load_set;
    set_idx_t     store_set;
    cache_tag_t   load_tag;
    cache_tag_t   store_tag;
    cache_block_t merged_block;

    assign load_set  = load_addr[`DCACHE_OFFSET_BITS +: `DCACHE_SET_BITS];
    assign load_tag  = load_addr[TAG_LSB +: `DCACHE_TAG_BITS];
    assign store_set = store_addr[`DCACHE_OFFSET_BITS +: `DCACHE_SET_BITS];
    assign store_tag = store_addr[TAG_LSB +: `DCACHE_TAG_BITS];

    // tag compare over all ways of each set
    always_comb begin
        load_hit      = 1'b0;
        load_hit_way  = '0;
        store_hit     = 1'b0;
        store_hit_way = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (valid_bits[load_set][w] && tags[load_set][w] == load_tag) begin
                load_hit     = 1'b1;
                load_hit_way = way_idx_t'(w);
            end
            if (valid_bits[store_set][w] && tags[store_set][w] == store_tag) begin
                store_hit     = 1'b1;
                store_hit_way = way_idx_t'(w);
            end
        end
    end

    assign load_hit_block = blocks[load_set][load_hit_way];

    // store bytes laid over the hit block
    always_comb begin
        merged_block = blocks[store_set][store_hit_way];
        case (store_size)
            byte_size: merged_block.bytes[store_addr[2:0]]  = store_data[7:0];
            half_size: merged_block.halves[store_addr[2:1]] = store_data[15:0];
            default:   merged_block.words[store_addr[2]]    = store_data;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (fill_valid) begin
            valid_bits[fill_set][fill_way] <= 1'b1;
        end
    end

    // fill comes last so a refill replaces a same-cycle store
    always_ff @(posedge clock) begin
        if (store_valid && store_hit) begin
            blocks[store_set][store_hit_way] <= merged_block;
        end
        if (fill_valid) begin
            blocks[fill_set][fill_way] <= fill_block;
            tags[fill_set][fill_way]   <= fill_tag;
        end
    end

endmodule

//--- dcache_load_result.sv
`timescale 1ns/1ps

module dcache_load_result (
    input  logic                     hit,
    input  dcache_pkg::addr_t        hit_addr,
    input  dcache_pkg::mem_size_t    hit_size,
    input  logic                     hit_signed,
    input  dcache_pkg::load_id_t     hit_id,
    input  dcache_pkg::cache_block_t hit_block,
    input  logic                     head_done,
    input  dcache_pkg::addr_t        head_addr,
    input  dcache_pkg::mem_size_t    head_size,
    input  logic                     head_signed,
    input  dcache_pkg::load_id_t     head_id,
    input  dcache_pkg::cache_block_t head_block,
    output logic                     result_valid,
    output logic [31:0]              result_data,
    output dcache_pkg::load_id_t     result_id
);
    import dcache_pkg::*;

    logic [2:0]   sel_offset;
    mem_size_t    sel_size;
    logic         sel_signed;
    cache_block_t sel_block;
    logic [7:0]   sel_byte;
    logic [15:0]  sel_half;

    // hit goes first and a done head waits
    assign result_valid = hit || head_done;
    assign result_id    = hit ? hit_id : head_id;
    assign sel_offset   = hit ? hit_addr[2:0] : head_addr[2:0];
    assign sel_size     = hit ? hit_size : head_size;
    assign sel_signed   = hit ? hit_signed : head_signed;
    assign sel_block    = hit ? hit_block : head_block;

    assign sel_byte = sel_block.bytes[sel_offset];
    assign sel_half = sel_block.halves[sel_offset[2:1]];

    always_comb begin
        case (sel_size)
            byte_size: result_data = {{24{sel_signed && sel_byte[7]}}, sel_byte};
            half_size: result_data = {{16{sel_signed && sel_half[15]}}, sel_half};
            default:   result_data = sel_block.words[sel_offset[2]];
        endcase
    end

endmodule

//--- dcache_miss_buffer.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_miss_buffer (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     flush,
    input  logic                     alloc_valid,
    input  dcache_pkg::addr_t        alloc_addr,
    input  dcache_pkg::mem_size_t    alloc_size,
    input  logic                     alloc_signed,
    input  dcache_pkg::load_id_t     alloc_id,
    input  dcache_pkg::way_idx_t     alloc_way,
    input  logic                     send_ready,
    input  dcache_pkg::mem_tag_t     send_tag,
    input  logic                     resp_valid,
    input  dcache_pkg::mem_tag_t     resp_tag,
    input  dcache_pkg::cache_block_t resp_data,
    input  logic                     retire_block,
    output logic                     full,
    output logic                     send_valid,
    output dcache_pkg::addr_t        send_addr,
    output logic                     head_done,
    output dcache_pkg::addr_t        head_addr,
    output dcache_pkg::mem_size_t    head_size,
    output logic                     head_signed,
    output dcache_pkg::load_id_t     head_id,
    output logic                     fill_valid,
    output dcache_pkg::set_idx_t     fill_set,
    output dcache_pkg::way_idx_t     fill_way,
    output dcache_pkg::cache_tag_t   fill_tag,
    output dcache_pkg::cache_block_t fill_block
);
    import dcache_pkg::*;

    localparam int TAG_LSB = `DCACHE_OFFSET_BITS + `DCACHE_SET_BITS;

    logic [`MISS_ENTRIES-1:0] ent_valid;
    logic [`MISS_ENTRIES-1:0] ent_sent;
    logic [`MISS_ENTRIES-1:0] ent_done;

    addr_t        ent_addr   [`MISS_ENTRIES];
    mem_size_t    ent_size   [`MISS_ENTRIES];
    logic         ent_signed [`MISS_ENTRIES];
    load_id_t     ent_id     [`MISS_ENTRIES];
    way_idx_t     ent_way    [`MISS_ENTRIES];
    mem_tag_t     ent_tag    [`MISS_ENTRIES];
    cache_block_t ent_block  [`MISS_ENTRIES];

    logic [`MISS_PTR_BITS-1:0] head_ptr;
    logic [`MISS_PTR_BITS-1:0] send_ptr;
    logic [`MISS_PTR_BITS-1:0] tail_ptr;
    logic                      send_fire;
    logic [`MISS_ENTRIES-1:0]  resp_match;

    assign full = ent_valid[head_ptr] && head_ptr == tail_ptr;

    // block read for the oldest unsent entry
    assign send_valid = ent_valid[send_ptr] && !ent_sent[send_ptr];
    assign send_addr  = {ent_addr[send_ptr][`DCACHE_ADDR_BITS-1:`DCACHE_OFFSET_BITS],
                         {`DCACHE_OFFSET_BITS{1'b0}}};
    assign send_fire  = send_valid && send_ready;

    // a flushed head gives no result
    assign head_done   = ent_valid[head_ptr] && ent_done[head_ptr] && !flush;
    assign head_addr   = ent_addr[head_ptr];
    assign head_size   = ent_size[head_ptr];
    assign head_signed = ent_signed[head_ptr];
    assign head_id     = ent_id[head_ptr];

    // retire writes the block into its chosen way
    assign fill_valid = head_done && !retire_block;
    assign fill_set   = head_addr[`DCACHE_OFFSET_BITS +: `DCACHE_SET_BITS];
    assign fill_way   = ent_way[head_ptr];
    assign fill_tag   = head_addr[TAG_LSB +: `DCACHE_TAG_BITS];
    assign fill_block = ent_block[head_ptr];

    always_comb begin
        for (int i = 0; i < `MISS_ENTRIES; i++) begin
            resp_match[i] = resp_valid && resp_tag != '0 && ent_valid[i] && ent_sent[i]
                            && !ent_done[i] && ent_tag[i] == resp_tag;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            ent_valid <= '0;
            ent_sent  <= '0;
            ent_done  <= '0;
            head_ptr  <= '0;
            send_ptr  <= '0;
            tail_ptr  <= '0;
        end else begin
            for (int i = 0; i < `MISS_ENTRIES; i++) begin
                if (resp_match[i]) begin
                    ent_done[i] <= 1'b1;
                end
            end
            if (alloc_valid) begin
                ent_valid[tail_ptr] <= 1'b1;
                ent_sent[tail_ptr]  <= 1'b0;
                ent_done[tail_ptr]  <= 1'b0;
                tail_ptr            <= tail_ptr + 1'b1;
            end
            if (send_fire) begin
                ent_sent[send_ptr] <= 1'b1;
                send_ptr           <= send_ptr + 1'b1;
            end
            if (fill_valid) begin
                ent_valid[head_ptr] <= 1'b0;
                head_ptr            <= head_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (alloc_valid) begin
            ent_addr[tail_ptr]   <= alloc_addr;
            ent_size[tail_ptr]   <= alloc_size;
            ent_signed[tail_ptr] <= alloc_signed;
            ent_id[tail_ptr]     <= alloc_id;
            ent_way[tail_ptr]    <= alloc_way;
        end
        // memory names the read as it accepts it
        if (send_fire) begin
            ent_tag[send_ptr] <= send_tag;
        end
        for (int i = 0; i < `MISS_ENTRIES; i++) begin
            if (resp_match[i]) begin
                ent_block[i] <= resp_data;
            end
        end
    end

endmodule

//--- dcache_pkg.sv
`include "dcache_settings.svh"

package dcache_pkg;

    typedef logic [`DCACHE_ADDR_BITS-1:0] addr_t;
    typedef logic [`DCACHE_SET_BITS-1:0]  set_idx_t;
    typedef logic [`DCACHE_WAY_BITS-1:0]  way_idx_t;
    typedef logic [`DCACHE_TAG_BITS-1:0]  cache_tag_t;
    typedef logic [`MEM_TAG_BITS-1:0]     mem_tag_t;
    typedef logic [`LOAD_ID_BITS-1:0]     load_id_t;

    typedef enum logic [1:0] {
        byte_size,
        half_size,
        word_size,
        block_size
    } mem_size_t;

    typedef enum logic [1:0] {
        cmd_none,
        cmd_load,
        cmd_store
    } mem_cmd_t;

    // one block word seen as bytes, halves or words
    typedef union packed {
        logic [`DCACHE_BLOCK_BITS/8-1:0][7:0]   bytes;
        logic [`DCACHE_BLOCK_BITS/16-1:0][15:0] halves;
        logic [`DCACHE_BLOCK_BITS/32-1:0][31:0] words;
    } cache_block_t;

endpackage

//--- dcache_plru.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_plru (
    input  logic                 clock,
    input  logic                 reset,
    input  dcache_pkg::set_idx_t lookup_set,
    input  logic                 touch_load,
    input  dcache_pkg::set_idx_t touch_load_set,
    input  dcache_pkg::way_idx_t touch_load_way,
    input  logic                 touch_store,
    input  dcache_pkg::set_idx_t touch_store_set,
    input  dcache_pkg::way_idx_t touch_store_way,
    output dcache_pkg::way_idx_t victim_way
);
    import dcache_pkg::*;

    // bit 0 picks the pair and bits 1 and 2 pick within ways 0/1 and 2/3
    logic [`DCACHE_SETS-1:0][2:0] tree_bits;
    logic [2:0]                   lookup_bits;
    logic                         touch;
    set_idx_t                     touch_set;
    way_idx_t                     touch_way;

    assign lookup_bits = tree_bits[lookup_set];

    // follow the tree toward the older side
    assign victim_way = lookup_bits[0] ? {1'b1, lookup_bits[2]} : {1'b0, lookup_bits[1]};

    // load hit wins over store hit
    assign touch     = touch_load || touch_store;
    assign touch_set = touch_load ? touch_load_set : touch_store_set;
    assign touch_way = touch_load ? touch_load_way : touch_store_way;

    always_ff @(posedge clock) begin
        if (reset) begin
            tree_bits <= '0;
        end else if (touch) begin
            // bits on the path point away from the used way
            tree_bits[touch_set][0] <= ~touch_way[1];
            if (touch_way[1]) begin
                tree_bits[touch_set][2] <= ~touch_way[0];
            end else begin
                tree_bits[touch_set][1] <= ~touch_way[0];
            end
        end
    end

endmodule

//--- dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// cache geometry
`define DCACHE_SETS        8
`define DCACHE_SET_BITS    3
`define DCACHE_WAYS        4
`define DCACHE_WAY_BITS    2
`define DCACHE_TAG_BITS    10
`define DCACHE_OFFSET_BITS 3

// bus widths
`define DCACHE_ADDR_BITS   32
`define DCACHE_BLOCK_BITS  64

// miss buffer
`define MISS_ENTRIES       4
`define MISS_PTR_BITS      2

// tag 0 means no transaction
`define MEM_TAG_BITS       4
`define LOAD_ID_BITS       5

`endif

//--- dcache_stim.txt
// op(0 load 1 store 2 flush 3 drain f end) flags(1 signed 2 hit 4 stall) size addr data expected
// expected bytes follow memory = addr[7:0] ^ addr[15:8]
0_0_2_00000100_00000000_02030001
3_0_0_00000000_00000000_00000000
0_2_2_00000100_00000000_02030001
0_2_2_00000104_00000000_06070405
0_1_0_00000180_00000000_FFFFFF81
3_0_0_00000000_00000000_00000000
0_3_0_00000181_00000000_FFFFFF80
0_2_0_00000182_00000000_00000083
0_3_0_00000183_00000000_FFFFFF82
0_2_0_00000184_00000000_00000085
0_3_0_00000185_00000000_FFFFFF84
0_2_0_00000186_00000000_00000087
0_3_0_00000187_00000000_FFFFFF86
0_2_0_00000180_00000000_00000081
0_3_1_00000180_00000000_FFFF8081
0_2_1_00000182_00000000_00008283
0_3_1_00000184_00000000_FFFF8485
0_2_1_00000186_00000000_00008687
0_3_1_00000102_00000000_00000203
1_0_0_00000105_000000AA_00000000
0_2_0_00000105_00000000_000000AA
0_2_2_00000104_00000000_0607AA05
1_0_2_00000180_DEADBEEF_00000000
0_2_2_00000180_00000000_DEADBEEF
1_0_1_00000242_00001234_00000000
0_0_1_00000242_00000000_00001234
3_0_0_00000000_00000000_00000000
0_0_2_00000308_00000000_08090A0B
0_0_2_00000310_00000000_10111213
0_0_2_00000318_00000000_18191A1B
0_0_2_00000320_00000000_20212223
0_4_2_00000328_00000000_28292A2B
3_0_0_00000000_00000000_00000000
0_0_2_00000400_00000000_00000000
0_0_2_00000448_00000000_00000000
2_0_0_00000000_00000000_00000000
3_0_0_00000000_00000000_00000000
0_0_2_00000408_00000000_0F0E0D0C
3_0_0_00000000_00000000_00000000
0_2_2_00000408_00000000_0F0E0D0C
f_0_0_00000000_00000000_00000000

//--- dcache_top.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_top (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          flush,
    input  logic                          load_valid,
    output logic                          load_ready,
    input  dcache_pkg::addr_t             load_addr,
    input  dcache_pkg::mem_size_t         load_size,
    input  logic                          load_signed,
    input  dcache_pkg::load_id_t          load_id,
    input  logic                          store_valid,
    output logic                          store_ready,
    input  dcache_pkg::addr_t             store_addr,
    input  dcache_pkg::mem_size_t         store_size,
    input  logic [31:0]                   store_data,
    output logic                          mem_req_valid,
    input  logic                          mem_req_ready,
    output dcache_pkg::mem_cmd_t          mem_req_cmd,
    output dcache_pkg::addr_t             mem_req_addr,
    output dcache_pkg::mem_size_t         mem_req_size,
    output logic [`DCACHE_BLOCK_BITS-1:0] mem_req_data,
    input  dcache_pkg::mem_tag_t          mem_req_tag,
    input  logic                          mem_resp_valid,
    input  dcache_pkg::mem_tag_t          mem_resp_tag,
    input  logic [`DCACHE_BLOCK_BITS-1:0] mem_resp_data,
    output logic                          result_valid,
    output logic [31:0]                   result_data,
    output dcache_pkg::load_id_t          result_id
);
    import dcache_pkg::*;

    logic         load_fire, load_hit, array_load_hit, miss_alloc, store_fire;
    logic         store_hit, miss_full, send_valid, send_ready, head_done;
    logic         head_signed, fill_valid;
    way_idx_t     load_hit_way, store_hit_way, victim_way, fill_way;
    cache_block_t load_hit_block, fill_block;
    addr_t        send_addr, head_addr;
    mem_size_t    head_size;
    load_id_t     head_id;
    set_idx_t     fill_set;
    cache_tag_t   fill_tag;

    assign load_ready  = !miss_full && !flush;
    assign load_fire   = load_valid && load_ready;
    assign load_hit    = load_fire && array_load_hit;
    assign miss_alloc  = load_fire && !array_load_hit;
    assign store_ready = mem_req_ready;
    assign store_fire  = store_valid && store_ready;

    // a store owns the memory port before any miss send
    assign send_ready    = mem_req_ready && !store_valid;
    assign mem_req_valid = store_valid || send_valid;
    assign mem_req_cmd   = store_valid ? cmd_store : (send_valid ? cmd_load : cmd_none);
    assign mem_req_addr  = store_valid ? store_addr : send_addr;
    assign mem_req_size  = store_valid ? store_size : block_size;
    assign mem_req_data  = store_valid ? {{(`DCACHE_BLOCK_BITS - 32){1'b0}}, store_data} : '0;

    dcache_plru plru_inst (
        .clock(clock), .reset(reset),
        .lookup_set(load_addr[`DCACHE_OFFSET_BITS +: `DCACHE_SET_BITS]),
        .touch_load(load_hit),
        .touch_load_set(load_addr[`DCACHE_OFFSET_BITS +: `DCACHE_SET_BITS]),
        .touch_load_way(load_hit_way),
        .touch_store(store_fire && store_hit),
        .touch_store_set(store_addr[`DCACHE_OFFSET_BITS +: `DCACHE_SET_BITS]),
        .touch_store_way(store_hit_way),
        .victim_way(victim_way)
    );

    dcache_array array_inst (
        .clock(clock), .reset(reset), .load_addr(load_addr),
        .store_valid(store_fire), .store_addr(store_addr), .store_size(store_size),
        .store_data(store_data), .fill_valid(fill_valid), .fill_set(fill_set),
        .fill_way(fill_way), .fill_tag(fill_tag), .fill_block(fill_block),
        .load_hit(array_load_hit), .load_hit_way(load_hit_way),
        .load_hit_block(load_hit_block), .store_hit(store_hit), .store_hit_way(store_hit_way)
    );

    dcache_miss_buffer miss_buffer_inst (
        .clock(clock), .reset(reset), .flush(flush),
        .alloc_valid(miss_alloc), .alloc_addr(load_addr), .alloc_size(load_size),
        .alloc_signed(load_signed), .alloc_id(load_id), .alloc_way(victim_way),
        .send_ready(send_ready), .send_tag(mem_req_tag),
        .resp_valid(mem_resp_valid), .resp_tag(mem_resp_tag), .resp_data(mem_resp_data),
        .retire_block(load_hit), .full(miss_full),
        .send_valid(send_valid), .send_addr(send_addr),
        .head_done(head_done), .head_addr(head_addr), .head_size(head_size),
        .head_signed(head_signed), .head_id(head_id),
        .fill_valid(fill_valid), .fill_set(fill_set), .fill_way(fill_way),
        .fill_tag(fill_tag), .fill_block(fill_block)
    );

    dcache_load_result load_result_inst (
        .hit(load_hit), .hit_addr(load_addr), .hit_size(load_size),
        .hit_signed(load_signed), .hit_id(load_id), .hit_block(load_hit_block),
        .head_done(head_done), .head_addr(head_addr), .head_size(head_size),
        .head_signed(head_signed), .head_id(head_id), .head_block(fill_block),
        .result_valid(result_valid), .result_data(result_data), .result_id(result_id)
    );

endmodule

//--- run_sim.sh
#!/bin/bash
# build and run the dcache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_dcache -f build.f -o sim_dcache \
    > build.log 2>&1 \
    && ./obj_dir/sim_dcache > sim.log 2>&1
grep -q "^Simulation passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- tb_dcache.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module tb_dcache;
    import dcache_pkg::*;

    logic        clock;
    logic        reset;
    logic        flush;
    logic        load_valid;
    logic        load_ready;
    addr_t       load_addr;
    mem_size_t   load_size;
    logic        load_signed;
    load_id_t    load_id;
    logic        store_valid;
    logic        store_ready;
    addr_t       store_addr;
    mem_size_t   store_size;
    logic [31:0] store_data;
    logic        mem_req_valid;
    logic        mem_req_ready = 1'b0;
    mem_cmd_t    mem_req_cmd;
    addr_t       mem_req_addr;
    mem_size_t   mem_req_size;
    logic [63:0] mem_req_data;
    mem_tag_t    mem_req_tag = 4'd1;
    logic        mem_resp_valid = 1'b0;
    mem_tag_t    mem_resp_tag = '0;
    logic [63:0] mem_resp_data = '0;
    logic        result_valid;
    logic [31:0] result_data;
    load_id_t    result_id;

    // op, flags, size, addr, data, expected
    logic [107:0] stim [0:63];
    logic [7:0]   mem_bytes [0:65535];
    load_id_t     miss_ids [$];
    logic [31:0]  miss_exp [$];
    addr_t        send_addrs [$];
    mem_tag_t     resp_tags [$];
    cache_block_t resp_blocks [$];
    int           resp_dues [$];

    integer      seed = 32'h2f6a;
    int          cycle = 0;
    int          limit = 0;
    int          num_lines;
    int          pick;
    mem_tag_t    next_tag = 4'd1;
    logic        cur_hit;
    logic [31:0] cur_exp;
    logic        stalled;
    logic [3:0]  op;
    logic [3:0]  flags;

    dcache_top dcache_top_inst (.*);

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "run stopped at cycle %0d", cycle);
    endtask

    task automatic check_result(input load_id_t exp_id, input logic [31:0] exp_data,
                                input load_id_t got_id, input logic [31:0] got_data);
        if (got_id !== exp_id)
            fail_now($sformatf("Mismatch result_id: expected %h, got %h", exp_id, got_id));
        if (got_data !== exp_data)
            fail_now($sformatf("Mismatch result_data: expected %h, got %h", exp_data, got_data));
    endtask

    task automatic check_mem_request(input mem_cmd_t exp_cmd, input addr_t exp_addr,
                                     input mem_cmd_t got_cmd, input addr_t got_addr);
        if (got_cmd !== exp_cmd)
            fail_now($sformatf("Mismatch mem_req_cmd: expected %h, got %h", exp_cmd, got_cmd));
        if (got_addr !== exp_addr)
            fail_now($sformatf("Mismatch mem_req_addr: expected %h, got %h", exp_addr, got_addr));
    endtask

    task automatic check_mem_payload(input mem_size_t exp_size, input logic [63:0] exp_data,
                                     input mem_size_t got_size, input logic [63:0] got_data);
        if (got_size !== exp_size)
            fail_now($sformatf("Mismatch mem_req_size: expected %h, got %h", exp_size, got_size));
        if (got_data !== exp_data)
            fail_now($sformatf("Mismatch mem_req_data: expected %h, got %h", exp_data, got_data));
    endtask

    function automatic cache_block_t read_block(input addr_t a);
        cache_block_t b;
        for (int i = 0; i < 8; i++) begin
            b.bytes[i] = mem_bytes[{a[15:3], 3'(i)}];
        end
        return b;
    endfunction

    task automatic write_store(input addr_t a, input mem_size_t s, input logic [31:0] d);
        int n;
        n = (s == byte_size) ? 1 : ((s == half_size) ? 2 : 4);
        for (int i = 0; i < n; i++) begin
            mem_bytes[16'(a[15:0] + i)] = d[8*i +: 8];
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // memory side driven on the falling edge
    always @(negedge clock) begin
        mem_req_ready  = ($random(seed) & 3) != 0;
        mem_req_tag    = next_tag;
        mem_resp_valid = 1'b0;
        pick = -1;
        for (int i = 0; i < resp_tags.size(); i++) begin
            if (pick < 0 && resp_dues[i] <= cycle) pick = i;
        end
        if (pick >= 0) begin
            mem_resp_valid = 1'b1;
            mem_resp_tag   = resp_tags[pick];
            mem_resp_data  = resp_blocks[pick];
            resp_tags.delete(pick);
            resp_blocks.delete(pick);
            resp_dues.delete(pick);
        end
    end

    // monitor of results and memory requests
    always @(posedge clock) begin
        cycle++;
        if (limit != 0 && cycle > limit) fail_now("timeout: the stimulus did not complete");
        if (!reset) begin
            if (load_valid && load_ready && cur_hit) begin
                if (!result_valid) fail_now("a load expected to hit gave no result that cycle");
                check_result(load_id, cur_exp, result_id, result_data);
            end else if (result_valid) begin
                if (miss_ids.size() == 0) fail_now("a result came for no pending load");
                check_result(miss_ids[0], miss_exp[0], result_id, result_data);
                void'(miss_ids.pop_front());
                void'(miss_exp.pop_front());
            end
            if (load_valid && load_ready && !cur_hit) begin
                miss_ids.push_back(load_id);
                miss_exp.push_back(cur_exp);
                send_addrs.push_back({load_addr[31:3], 3'b000});
            end
            if (mem_req_valid && mem_req_ready) begin
                if (store_valid) begin
                    check_mem_request(cmd_store, store_addr, mem_req_cmd, mem_req_addr);
                    check_mem_payload(store_size, {32'h0, store_data}, mem_req_size, mem_req_data);
                    write_store(store_addr, store_size, store_data);
                end else begin
                    if (send_addrs.size() == 0) fail_now("an unexpected block read went out");
                    check_mem_request(cmd_load, send_addrs.pop_front(), mem_req_cmd, mem_req_addr);
                    check_mem_payload(block_size, '0, mem_req_size, mem_req_data);
                    resp_tags.push_back(mem_req_tag);
                    resp_blocks.push_back(read_block(mem_req_addr));
                    resp_dues.push_back(cycle + 1 + ($unsigned($random(seed)) % 6));
                    next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
                end
            end
        end
    end

    initial begin
        for (int a = 0; a < 65536; a++) begin
            mem_bytes[a] = 8'(a) ^ 8'(a >> 8);
        end
        $readmemh("dcache_stim.txt", stim);
        num_lines = 0;
        while (num_lines < 64 && stim[num_lines][107:104] != 4'hf) num_lines++;
        limit = 40 * num_lines + 200;
        reset = 1'b1;
        flush = 1'b0;
        load_valid = 1'b0;
        load_addr = '0;
        load_size = byte_size;
        load_signed = 1'b0;
        load_id = '0;
        store_valid = 1'b0;
        store_addr = '0;
        store_size = byte_size;
        store_data = '0;
        cur_hit = 1'b0;
        cur_exp = '0;
        repeat (16) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        for (int n = 0; n < num_lines; n++) begin
            op    = stim[n][107:104];
            flags = stim[n][103:100];
            case (op)
                4'h0: begin
                    load_valid  = 1'b1;
                    load_addr   = stim[n][95:64];
                    load_size   = mem_size_t'(stim[n][97:96]);
                    load_signed = flags[0];
                    cur_hit     = flags[1];
                    cur_exp     = stim[n][31:0];
                    stalled     = 1'b0;
                    @(posedge clock);
                    while (!load_ready) begin
                        stalled = 1'b1;
                        @(posedge clock);
                    end
                    @(negedge clock);
                    load_valid = 1'b0;
                    load_id    = load_id + 1'b1;
                    if (flags[2] && !stalled) begin
                        fail_now("a load was accepted while the buffer was full");
                    end
                end
                4'h1: begin
                    store_valid = 1'b1;
                    store_addr  = stim[n][95:64];
                    store_size  = mem_size_t'(stim[n][97:96]);
                    store_data  = stim[n][63:32];
                    @(posedge clock);
                    while (!store_ready) @(posedge clock);
                    @(negedge clock);
                    store_valid = 1'b0;
                end
                4'h2: begin
                    flush = 1'b1;
                    @(negedge clock);
                    flush = 1'b0;
                    miss_ids.delete();
                    miss_exp.delete();
                    send_addrs.delete();
                end
                default: begin
                    while (miss_ids.size() != 0 || send_addrs.size() != 0 || resp_tags.size() != 0)
                        @(negedge clock);
                end
            endcase
        end
        $display("Simulation passed");
        $finish;
    end

endmodule
